// ==== verilog/spm_cfg.svh ====
`ifndef SPM_CFG_SVH
`define SPM_CFG_SVH

//////////////////////////////
// Datapath sizing
//////////////////////////////

// Width of every data word on the position path
`define SPM_DATA_W 32

// Fraction bits of the cos and sin coefficients
`define SPM_QROT 28

// One update tick every 2**SPM_RATE_BITS clocks
`define SPM_RATE_BITS 2

// Symmetric Z saturation magnitude
`define SPM_Z_MAX 32'sh7fff_ffff

`endif

// ==== verilog/spm_pkg.sv ====
`include "spm_cfg.svh"

package spm_pkg;

    // Common signed data word
    typedef logic signed [`SPM_DATA_W-1:0] word_t;

    // Raw scan, servo and bias inputs
    typedef struct packed {
        word_t xs;
        word_t ys;
        word_t zs;
        word_t z_servo;
        word_t u;
    } scan_in_t;

    // Absolute offset setpoints
    typedef struct packed {
        word_t x0;
        word_t y0;
        word_t z0;
        word_t u0;
    } setpoint_t;

    // Rotation coefficients, cos then sin
    typedef struct packed {
        word_t xx;
        word_t xy;
    } rot_t;

    // Largest offset change per tick
    typedef struct packed {
        word_t xy_step;
        word_t z_step;
    } step_t;

    // Everything sampled at one tick
    typedef struct packed {
        scan_in_t  scan;
        setpoint_t setpoint;
        rot_t      rot;
        step_t     step;
    } frame_t;

    // Rotated pair plus the terms carried beside it
    typedef struct packed {
        word_t xr;
        word_t yr;
        word_t zs;
        word_t z_servo;
        word_t u;
    } rotated_t;

    typedef struct packed {
        word_t x;
        word_t y;
        word_t z;
        word_t u;
    } drive_t;

    typedef struct packed {
        word_t xs;
        word_t ys;
        word_t zs;
        word_t x0;
        word_t y0;
        word_t z0;
        word_t u_ref;
    } monitor_t;

    // Last move of an offset follower
    typedef enum logic [1:0] {
        SLEW_HOLD,
        SLEW_UP,
        SLEW_DOWN
    } slew_dir_e;

endpackage

// ==== verilog/spm_update_sequencer.sv ====
`include "spm_cfg.svh"

module spm_update_sequencer (
    input  logic               a_clk,
    input  logic               rst,
    input  spm_pkg::scan_in_t  scan_in,
    input  spm_pkg::setpoint_t setpoint,
    input  spm_pkg::rot_t      rot,
    input  spm_pkg::step_t     step,
    output logic               tick,
    output spm_pkg::frame_t    frame
);

    logic [`SPM_RATE_BITS-1:0] rate_cnt;

    //////////////////////////////
    // Rate divider
    //////////////////////////////

    // Free running, wraps every 2**SPM_RATE_BITS clocks
    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            rate_cnt <= '0;
        end
        else
        begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // Zero count marks the update slot, so the first
    // cycle out of reset is already a tick
    assign tick = (rate_cnt == '0);

    //////////////////////////////
    // Frame capture
    //////////////////////////////

    // All inputs latched together so downstream stages
    // never mix values from different ticks
    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            frame <= '0;
        end
        else if (tick)
        begin
            // Scan vector, servo and bias
            frame.scan     <= scan_in;
            // Offset targets and bias reference
            frame.setpoint <= setpoint;
            // Rotation matrix coefficients
            frame.rot      <= rot;
            // Ramp limits for the offset followers
            frame.step     <= step;
        end
    end

endmodule

// ==== verilog/spm_offset_slew.sv ====
module spm_offset_slew (
    input  logic               a_clk,
    input  logic               rst,
    input  logic               tick,
    input  spm_pkg::word_t     target,
    input  spm_pkg::word_t     step,
    output spm_pkg::word_t     offset,
    output spm_pkg::slew_dir_e dir
);

    // Candidate positions one step either side
    spm_pkg::word_t offset_up;
    spm_pkg::word_t offset_dn;

    // Wraps if offset sits within one step of full scale
    assign offset_up = offset + step;
    assign offset_dn = offset - step;

    // Rate limited follower, a jump becomes a linear ramp
    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            offset <= '0;
            dir    <= spm_pkg::SLEW_HOLD;
        end
        else if (tick)
        begin
            if (target > offset_up)
            begin
                offset <= offset_up;
                dir    <= spm_pkg::SLEW_UP;
            end
            else if (target < offset_dn)
            begin
                offset <= offset_dn;
                dir    <= spm_pkg::SLEW_DOWN;
            end
            else
            begin
                // Within one step, land exactly on target
                offset <= target;
                dir    <= spm_pkg::SLEW_HOLD;
            end
        end
    end

endmodule

// ==== verilog/spm_scan_rotator.sv ====
`include "spm_cfg.svh"

module spm_scan_rotator (
    input  logic              a_clk,
    input  logic              rst,
    input  logic              tick,
    input  spm_pkg::scan_in_t scan,
    input  spm_pkg::rot_t     rot,
    output spm_pkg::rotated_t rotated
);

    localparam int PROD_W = 2 * `SPM_DATA_W;
    localparam int SUM_W  = PROD_W + 1;

    spm_pkg::word_t xs;
    spm_pkg::word_t ys;
    spm_pkg::word_t cos_a;
    spm_pkg::word_t sin_a;

    logic signed [PROD_W-1:0] p_cos_xs;
    logic signed [PROD_W-1:0] p_sin_ys;
    logic signed [PROD_W-1:0] p_cos_ys;
    logic signed [PROD_W-1:0] p_sin_xs;

    logic signed [SUM_W-1:0] sum_x;
    logic signed [SUM_W-1:0] sum_y;
    logic signed [SUM_W-1:0] shr_x;
    logic signed [SUM_W-1:0] shr_y;

    assign xs    = scan.xs;
    assign ys    = scan.ys;
    assign cos_a = rot.xx;
    assign sin_a = rot.xy;

    //////////////////////////////
    // Matrix multiply
    //////////////////////////////

    // Full precision products, no rounding before the shift
    assign p_cos_xs = PROD_W'(cos_a) * PROD_W'(xs);
    assign p_sin_ys = PROD_W'(sin_a) * PROD_W'(ys);
    assign p_cos_ys = PROD_W'(cos_a) * PROD_W'(ys);
    assign p_sin_xs = PROD_W'(sin_a) * PROD_W'(xs);

    // Upper row is cos sin, lower row is -sin cos
    assign sum_x = SUM_W'(p_cos_xs) + SUM_W'(p_sin_ys);
    assign sum_y = SUM_W'(p_cos_ys) - SUM_W'(p_sin_xs);

    // Back from Q SPM_QROT to plain units
    assign shr_x = sum_x >>> `SPM_QROT;
    assign shr_y = sum_y >>> `SPM_QROT;

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            rotated <= '0;
        end
        else if (tick)
        begin
            rotated.xr      <= shr_x[`SPM_DATA_W-1:0];
            rotated.yr      <= shr_y[`SPM_DATA_W-1:0];
            // Z and bias terms kept aligned with the rotated pair
            rotated.zs      <= scan.zs;
            rotated.z_servo <= scan.z_servo;
            rotated.u       <= scan.u;
        end
    end

endmodule

// ==== verilog/spm_output_mixer.sv ====
`include "spm_cfg.svh"

module spm_output_mixer (
    input  logic              a_clk,
    input  logic              rst,
    input  logic              tick,
    input  spm_pkg::rotated_t rotated,
    input  spm_pkg::word_t    x_offset,
    input  spm_pkg::word_t    y_offset,
    input  spm_pkg::word_t    z_offset,
    input  spm_pkg::word_t    u_ref,
    output spm_pkg::drive_t   drive,
    output logic              drive_strobe
);

    // Two guard bits for the three term Z sum
    localparam int Z_SUM_W = `SPM_DATA_W + 2;
    localparam logic signed [Z_SUM_W-1:0] Z_HI = Z_SUM_W'(`SPM_Z_MAX);
    localparam logic signed [Z_SUM_W-1:0] Z_LO = -Z_HI;

    logic [1:0]                fill_cnt;
    logic                      filled;
    spm_pkg::word_t            u_ref_d;
    logic signed [Z_SUM_W-1:0] z_sum;
    spm_pkg::word_t            z_sat;

    // Pipeline holds real data after two ticks
    assign filled = (fill_cnt == 2'd2);

    //////////////////////////////
    // Z sum and clamp
    //////////////////////////////

    assign z_sum = Z_SUM_W'(z_offset) + Z_SUM_W'(rotated.zs) + Z_SUM_W'(rotated.z_servo);

    always_comb
    begin
        if (z_sum > Z_HI)
        begin
            z_sat = Z_HI[`SPM_DATA_W-1:0];
        end
        else if (z_sum < Z_LO)
        begin
            z_sat = Z_LO[`SPM_DATA_W-1:0];
        end
        else
        begin
            z_sat = z_sum[`SPM_DATA_W-1:0];
        end
    end

    //////////////////////////////
    // Drive registers
    //////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            fill_cnt     <= '0;
            u_ref_d      <= '0;
            drive        <= '0;
            drive_strobe <= 1'b0;
        end
        else
        begin
            drive_strobe <= tick && filled;
            if (tick)
            begin
                // u0 delayed one stage to meet u from the same frame
                u_ref_d <= u_ref;
                if (filled)
                begin
                    // X, Y and U wrap on overflow
                    drive.x <= rotated.xr + x_offset;
                    drive.y <= rotated.yr + y_offset;
                    drive.z <= z_sat;
                    drive.u <= u_ref_d + rotated.u;
                end
                else
                begin
                    fill_cnt <= fill_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/spm_position_top.sv ====
module spm_position_top (
    input  logic                         a_clk,
    input  logic                         rst,
    input  spm_pkg::scan_in_t            scan_in,
    input  spm_pkg::setpoint_t           setpoint,
    input  spm_pkg::rot_t                rot,
    input  spm_pkg::step_t               step,
    output spm_pkg::drive_t              drive,
    output logic                         drive_strobe,
    output spm_pkg::monitor_t            monitor,
    // Index 0 is x, 1 is y, 2 is z
    output spm_pkg::slew_dir_e [2:0]     slew_state
);

    logic              tick;
    spm_pkg::frame_t   frame;
    spm_pkg::rotated_t rotated;
    spm_pkg::word_t    x_offset;
    spm_pkg::word_t    y_offset;
    spm_pkg::word_t    z_offset;

    //////////////////////////////
    // Tick and input sampling
    //////////////////////////////

    spm_update_sequencer i_spm_update_sequencer (
        .a_clk    (a_clk),
        .rst      (rst),
        .scan_in  (scan_in),
        .setpoint (setpoint),
        .rot      (rot),
        .step     (step),
        .tick     (tick),
        .frame    (frame)
    );

    //////////////////////////////
    // Offset followers
    //////////////////////////////

    // X and Y share the lateral ramp rate
    spm_offset_slew i_spm_offset_slew_x (
        .a_clk  (a_clk),
        .rst    (rst),
        .tick   (tick),
        .target (frame.setpoint.x0),
        .step   (frame.step.xy_step),
        .offset (x_offset),
        .dir    (slew_state[0])
    );

    spm_offset_slew i_spm_offset_slew_y (
        .a_clk  (a_clk),
        .rst    (rst),
        .tick   (tick),
        .target (frame.setpoint.y0),
        .step   (frame.step.xy_step),
        .offset (y_offset),
        .dir    (slew_state[1])
    );

    spm_offset_slew i_spm_offset_slew_z (
        .a_clk  (a_clk),
        .rst    (rst),
        .tick   (tick),
        .target (frame.setpoint.z0),
        .step   (frame.step.z_step),
        .offset (z_offset),
        .dir    (slew_state[2])
    );

    //////////////////////////////
    // Rotation and output mix
    //////////////////////////////

    spm_scan_rotator i_spm_scan_rotator (
        .a_clk   (a_clk),
        .rst     (rst),
        .tick    (tick),
        .scan    (frame.scan),
        .rot     (frame.rot),
        .rotated (rotated)
    );

    spm_output_mixer i_spm_output_mixer (
        .a_clk        (a_clk),
        .rst          (rst),
        .tick         (tick),
        .rotated      (rotated),
        .x_offset     (x_offset),
        .y_offset     (y_offset),
        .z_offset     (z_offset),
        .u_ref        (frame.setpoint.u0),
        .drive        (drive),
        .drive_strobe (drive_strobe)
    );

    // Monitor shows the newest frame and live offsets
    assign monitor.xs    = frame.scan.xs;
    assign monitor.ys    = frame.scan.ys;
    assign monitor.zs    = frame.scan.zs;
    assign monitor.x0    = x_offset;
    assign monitor.y0    = y_offset;
    assign monitor.z0    = z_offset;
    assign monitor.u_ref = frame.setpoint.u0;

endmodule

// ==== tb/spm_position_assertions.sv ====
`include "spm_cfg.svh"

module spm_position_assertions (
    input logic           a_clk,
    input logic           rst,
    input logic           tick,
    input logic           strobe,
    input spm_pkg::word_t z_drive
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD = 1 << `SPM_RATE_BITS;

    // No second tick inside one rate period
    for (genvar j = 1; j < PERIOD; j++)
    begin : g_tick_gap
        a_tick_gap: assert property (@(posedge a_clk) disable iff (rst)
            (tick && !$past(rst, j)) |-> !$past(tick, j))
            else $error("tick closer than one rate period to the previous tick");
    end

    // Each tick one full period after the previous
    a_tick_period: assert property (@(posedge a_clk) disable iff (rst)
        (tick && !$past(rst, PERIOD)) |-> $past(tick, PERIOD))
        else $error("tick spacing differs from the rate period");

    // Strobe only in the cycle after an update tick
    a_strobe_after_tick: assert property (@(posedge a_clk) disable iff (rst)
        strobe |-> $past(tick)) else $error("drive_strobe without a preceding tick");

    a_z_range: assert property (@(posedge a_clk) disable iff (rst)
        z_drive >= -`SPM_Z_MAX) else $error("drive.z below the negative clamp");

endmodule

bind spm_update_sequencer spm_position_assertions i_seq_assertions (
    .a_clk(a_clk), .rst(rst), .tick(tick), .strobe(1'b0), .z_drive('0)
);

bind spm_output_mixer spm_position_assertions i_mix_assertions (
    .a_clk(a_clk), .rst(rst), .tick(tick), .strobe(drive_strobe), .z_drive(drive.z)
);

// ==== tb/spm_position_tb.sv ====
`include "spm_cfg.svh"

module spm_position_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_FRAMES  = 74;
    localparam int MAX_CYCLE = 5 + (N_FRAMES + 4) * (1 << `SPM_RATE_BITS) + 40;

    logic                          a_clk = 1'b0;
    logic                          rst;
    spm_pkg::scan_in_t             scan_in;
    spm_pkg::setpoint_t            setpoint;
    spm_pkg::rot_t                 rot;
    spm_pkg::step_t                step;
    spm_pkg::drive_t               drive;
    logic                          drive_strobe;
    spm_pkg::monitor_t             monitor;
    spm_pkg::slew_dir_e [2:0]      slew_state;

    logic [31:0]                   seed = 32'he3dc;
    int                            cycle_cnt = 0;
    int                            strobe_cnt = 0;
    spm_pkg::frame_t               frames [N_FRAMES];
    spm_pkg::word_t                off_hist [N_FRAMES][3];
    spm_pkg::slew_dir_e            dir_hist [N_FRAMES][3];

    spm_position_top i_spm_position_top (
        .a_clk(a_clk), .rst(rst), .scan_in(scan_in), .setpoint(setpoint), .rot(rot),
        .step(step), .drive(drive), .drive_strobe(drive_strobe), .monitor(monitor),
        .slew_state(slew_state)
    );

    always #20 a_clk = ~a_clk;

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    task automatic slew_model(input spm_pkg::word_t off, input spm_pkg::word_t target,
                              input spm_pkg::word_t stp, output spm_pkg::word_t nxt,
                              output spm_pkg::slew_dir_e dir);
        spm_pkg::word_t up;
        spm_pkg::word_t dn;
        up = off + stp;
        dn = off - stp;
        if (target > up)
        begin
            nxt = up;
            dir = spm_pkg::SLEW_UP;
        end
        else if (target < dn)
        begin
            nxt = dn;
            dir = spm_pkg::SLEW_DOWN;
        end
        else
        begin
            nxt = target;
            dir = spm_pkg::SLEW_HOLD;
        end
    endtask

    // Rotate, add offsets, clamp Z and add bias for one frame
    function automatic spm_pkg::drive_t ref_drive(spm_pkg::frame_t f, spm_pkg::word_t xo,
                                                  spm_pkg::word_t yo, spm_pkg::word_t zo);
        logic signed [64:0] a_xx;
        logic signed [64:0] a_xy;
        logic signed [64:0] a_xs;
        logic signed [64:0] a_ys;
        logic signed [64:0] sx;
        logic signed [64:0] sy;
        logic signed [33:0] zsum;
        logic signed [33:0] zmax;
        spm_pkg::drive_t    d;
        a_xx = f.rot.xx;
        a_xy = f.rot.xy;
        a_xs = f.scan.xs;
        a_ys = f.scan.ys;
        sx = (a_xx * a_xs + a_xy * a_ys) >>> `SPM_QROT;
        sy = (a_xx * a_ys - a_xy * a_xs) >>> `SPM_QROT;
        d.x = sx[31:0] + xo;
        d.y = sy[31:0] + yo;
        zmax = 34'(`SPM_Z_MAX);
        zsum = 34'(zo) + 34'(f.scan.zs) + 34'(f.scan.z_servo);
        if (zsum > zmax)
            d.z = zmax[31:0];
        else if (zsum < -zmax)
            d.z = 32'(-zmax);
        else
            d.z = zsum[31:0];
        d.u = f.setpoint.u0 + f.scan.u;
        return d;
    endfunction

    // One behavior per range of frame index
    function automatic spm_pkg::frame_t make_frame(int n);
        spm_pkg::frame_t f;
        f = '0;
        f.rot.xx = 32'sd1 <<< `SPM_QROT;
        f.step.xy_step = 32'sd100;
        f.step.z_step = 32'sd50;
        f.scan.xs = next_rand();
        f.scan.ys = next_rand();
        f.scan.u = next_rand();
        if (n >= 6)
        begin
            // Setpoint jump that ramps over many ticks
            f.setpoint.x0 = 32'sd1500;
            f.setpoint.y0 = -32'sd1200;
            f.setpoint.z0 = 32'sd700;
            f.setpoint.u0 = 32'sd42;
            f.scan.xs = f.scan.xs >>> 8;
            f.scan.ys = f.scan.ys >>> 8;
        end
        if (n >= 26 && n < 34)
        begin
            case (n % 4)
                0:
                begin
                    f.scan.zs = 32'sh7000_0000;
                    f.scan.z_servo = 32'sh6000_0000;
                end
                1:
                begin
                    f.scan.zs = -32'sh7000_0000;
                    f.scan.z_servo = -32'sh6000_0000;
                end
                2:
                begin
                    f.scan.zs = 32'sd1234;
                    f.scan.z_servo = -32'sd567;
                end
                default:
                begin
                    f.scan.zs = -32'sd99;
                    f.scan.z_servo = 32'sd12;
                end
            endcase
        end
        if (n >= 34)
        begin
            f.scan.zs = next_rand();
            f.scan.z_servo = next_rand();
            f.setpoint.x0 = next_rand();
            f.setpoint.y0 = next_rand();
            f.setpoint.z0 = next_rand();
            f.setpoint.u0 = next_rand();
            f.rot.xx = next_rand();
            f.rot.xy = next_rand();
            f.step.xy_step = next_rand() & 32'h0000_ffff;
            f.step.z_step = next_rand() & 32'h0000_ffff;
        end
        return f;
    endfunction

    ////////////////////////////////
    // Compare tasks
    ////////////////////////////////

    task automatic check_drive(string name, spm_pkg::drive_t exp, spm_pkg::drive_t act);
        if (exp !== act)
        begin
            $display("MISMATCH at %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_monitor(string name, spm_pkg::monitor_t exp, spm_pkg::monitor_t act);
        if (exp !== act)
        begin
            $display("MISMATCH at %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_slew(string name, spm_pkg::slew_dir_e exp, spm_pkg::slew_dir_e act);
        if (exp !== act)
        begin
            $display("MISMATCH at %0t %s expected %s actual %s", $time, name,
                     exp.name(), act.name());
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Strobe m carries frame m while monitor shows frame m+2
    always @(posedge a_clk)
    begin
        spm_pkg::monitor_t mon_exp;
        int m;
        if (!rst && drive_strobe)
        begin
            m = strobe_cnt;
            if (m + 2 >= N_FRAMES)
            begin
                $display("Unexpected drive_strobe after the last frame at %0t", $time);
                $display("Something failed");
                $fatal(1);
            end
            else
            begin
                check_drive("drive", ref_drive(frames[m], off_hist[m + 1][0],
                            off_hist[m + 1][1], off_hist[m + 1][2]), drive);
                mon_exp.xs = frames[m + 2].scan.xs;
                mon_exp.ys = frames[m + 2].scan.ys;
                mon_exp.zs = frames[m + 2].scan.zs;
                mon_exp.x0 = off_hist[m + 2][0];
                mon_exp.y0 = off_hist[m + 2][1];
                mon_exp.z0 = off_hist[m + 2][2];
                mon_exp.u_ref = frames[m + 2].setpoint.u0;
                check_monitor("monitor", mon_exp, monitor);
                check_slew("slew_state[0]", dir_hist[m + 2][0], slew_state[0]);
                check_slew("slew_state[1]", dir_hist[m + 2][1], slew_state[1]);
                check_slew("slew_state[2]", dir_hist[m + 2][2], slew_state[2]);
                strobe_cnt <= strobe_cnt + 1;
            end
        end
    end

    always @(posedge a_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLE)
        begin
            $display("Timeout, the drive strobes did not all arrive in time");
            $display("Something failed");
            $fatal(1);
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    initial
    begin
        spm_pkg::frame_t f;
        rst = 1'b1;
        scan_in = '0;
        setpoint = '0;
        rot = '0;
        step = '0;
        repeat (5) @(posedge a_clk);
        for (int n = 0; n < N_FRAMES; n++)
        begin
            f = make_frame(n);
            frames[n] = f;
            // Offsets after tick n move toward frame n-1
            for (int k = 0; k < 3; k++)
            begin
                if (n == 0)
                begin
                    off_hist[n][k] = '0;
                    dir_hist[n][k] = spm_pkg::SLEW_HOLD;
                end
                else
                begin
                    slew_model(off_hist[n - 1][k],
                               (k == 0) ? frames[n - 1].setpoint.x0 :
                               (k == 1) ? frames[n - 1].setpoint.y0 : frames[n - 1].setpoint.z0,
                               (k == 2) ? frames[n - 1].step.z_step : frames[n - 1].step.xy_step,
                               off_hist[n][k], dir_hist[n][k]);
                end
            end
            rst <= 1'b0;
            scan_in <= f.scan;
            setpoint <= f.setpoint;
            rot <= f.rot;
            step <= f.step;
            repeat (1 << `SPM_RATE_BITS) @(posedge a_clk);
        end
        wait (strobe_cnt == N_FRAMES - 2);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/spm_pkg.sv
verilog/spm_update_sequencer.sv
verilog/spm_offset_slew.sv
verilog/spm_scan_rotator.sv
verilog/spm_output_mixer.sv
verilog/spm_position_top.sv
tb/spm_position_assertions.sv
tb/spm_position_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' flist.f) verilog/spm_cfg.svh
SIM  := obj_dir/Vspm_position_tb

.PHONY: all run check clean

all: check

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module spm_position_tb -Mdir obj_dir

sim.log: $(SIM)
	./$(SIM) > sim.log 2>&1 || true

run: sim.log
	cat sim.log

check: sim.log
	@grep -q "Everything OK" sim.log && echo "PASS" || (echo "FAIL, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
